// File: src/tia_reg_pkg.sv
package tia_reg_pkg;

  // APB port geometry.
  localparam int apb_addr_w = 3;
  localparam int data_w     = 8;

  // Register offsets. Offsets 5 to 7 are unmapped.
  localparam logic [apb_addr_w-1:0] addr_colup0 = 3'd0;  // Player 0 and missile 0.
  localparam logic [apb_addr_w-1:0] addr_colup1 = 3'd1;  // Player 1 and missile 1.
  localparam logic [apb_addr_w-1:0] addr_colupf = 3'd2;  // Playfield and ball.
  localparam logic [apb_addr_w-1:0] addr_colubk = 3'd3;  // Background.
  localparam logic [apb_addr_w-1:0] addr_ctrlpf = 3'd4;  // Score and priority control.

  // Colour registers keep data bits 7:1, bit 0 is not stored.
  localparam int color_msb = 7;
  localparam int color_lsb = 1;

  // CTRLPF control bits, same positions as the original chip.
  localparam int ctrlpf_score_bit = 1;
  localparam int ctrlpf_pfp_bit   = 2;

endpackage

// File: src/tia_video_pkg.sv
package tia_video_pkg;

  // Output field widths.
  localparam int lum_w = 3;
  localparam int hue_w = 4;

  // One colour register, hue above luminance as in the written byte.
  typedef struct packed {
    logic [hue_w-1:0] hue;  // Data bits 7:4.
    logic [lum_w-1:0] lum;  // Data bits 3:1.
  } color_t;

  // Source that wins the priority for the current pixel.
  typedef enum logic [2:0] {
    src_none,  // Blanked, output is forced to zero.
    src_p0,
    src_p1,
    src_pf,
    src_bk
  } obj_src_t;

endpackage

// File: src/tia_color_if.sv
`timescale 1ns/10ps

interface tia_color_if;
  import tia_video_pkg::*;

  color_t colup0;  // Player 0 and missile 0.
  color_t colup1;  // Player 1 and missile 1.
  color_t colupf;  // Playfield and ball.
  color_t colubk;  // Background.
  logic   score;
  logic   pfp;

  modport regs (
    output colup0, colup1, colupf, colubk,
    output score, pfp
  );

  modport video (
    input colup0, colup1, colupf, colubk,
    input score, pfp
  );

endinterface

// File: src/tia_obj_if.sv
`timescale 1ns/10ps

interface tia_obj_if;

  logic p0;  // Player 0 graphics.
  logic m0;  // Missile 0.
  logic p1;  // Player 1 graphics.
  logic m1;  // Missile 1.
  logic pf;  // Playfield.
  logic bl;  // Ball.

  modport src (output p0, m0, p1, m1, pf, bl);

  modport video (input p0, m0, p1, m1, pf, bl);

endinterface

// File: src/tia_apb_regs.sv
`timescale 1ns/10ps

module tia_apb_regs (
  input  logic                               clkp,
  input  logic                               reset,
  input  logic                               psel,
  input  logic                               penable,
  input  logic                               pwrite,
  input  logic [tia_reg_pkg::apb_addr_w-1:0] paddr,
  input  logic [tia_reg_pkg::data_w-1:0]     pwdata,
  output logic [tia_reg_pkg::data_w-1:0]     prdata,
  output logic                               pready,
  output logic                               pslverr,
  tia_color_if.regs                          colors
);

  import tia_reg_pkg::*;
  import tia_video_pkg::*;

  logic              access;
  logic              mapped;
  logic              wr_en;
  color_t            wr_color;
  logic [data_w-1:0] rd_data;

  assign access   = psel & penable;  // Access phase.
  assign wr_en    = access & pwrite & mapped;
  assign wr_color = pwdata[color_msb:color_lsb];

  // Address decode and read mux.
  always_comb begin
    mapped  = 1'b1;
    rd_data = '0;
    case (paddr)
      addr_colup0: rd_data[color_msb:color_lsb] = colors.colup0;
      addr_colup1: rd_data[color_msb:color_lsb] = colors.colup1;
      addr_colupf: rd_data[color_msb:color_lsb] = colors.colupf;
      addr_colubk: rd_data[color_msb:color_lsb] = colors.colubk;
      addr_ctrlpf: begin
        rd_data[ctrlpf_score_bit] = colors.score;
        rd_data[ctrlpf_pfp_bit]   = colors.pfp;
      end
      default: mapped = 1'b0;  // Reads as zero.
    endcase
  end

  always_ff @(posedge clkp) begin
    if (reset) begin
      colors.colup0 <= '0;
      colors.colup1 <= '0;
      colors.colupf <= '0;
      colors.colubk <= '0;
      colors.score  <= 1'b0;
      colors.pfp    <= 1'b0;
    end else if (wr_en) begin
      case (paddr)
        addr_colup0: colors.colup0 <= wr_color;
        addr_colup1: colors.colup1 <= wr_color;
        addr_colupf: colors.colupf <= wr_color;
        addr_colubk: colors.colubk <= wr_color;
        addr_ctrlpf: begin
          colors.score <= pwdata[ctrlpf_score_bit];
          colors.pfp   <= pwdata[ctrlpf_pfp_bit];
        end
        default: ;
      endcase
    end
  end

  // Zero wait states, so every access phase completes at once.
  assign pready  = access;
  assign pslverr = access & ~mapped;
  assign prdata  = (access & ~pwrite) ? rd_data : '0;

endmodule

// File: src/tia_color_priority.sv
`timescale 1ns/10ps

module tia_color_priority (
  input  logic                            clkp,
  input  logic                            reset,
  input  logic                            blank,
  input  logic                            cntd,
  tia_color_if.video                      colors,
  tia_obj_if.video                        objs,
  output logic [tia_video_pkg::lum_w-1:0] lum,
  output logic [tia_video_pkg::hue_w-1:0] hue,
  output logic                            blk_bar
);

  import tia_video_pkg::*;

  logic     left_half;  // Set in the left half of the line.
  logic     pf_or_bl;
  logic     pf_top;
  logic     score_pf;
  logic     p0_hit;
  logic     p1_hit;
  obj_src_t win;
  color_t   sel_color;

  // Screen half tracker, blank wins over the centre count.
  always_ff @(posedge clkp) begin
    if (reset) begin
      left_half <= 1'b0;
    end else if (blank) begin
      left_half <= 1'b1;
    end else if (cntd) begin
      left_half <= 1'b0;
    end
  end

  assign pf_or_bl = objs.pf | objs.bl;
  assign pf_top   = colors.pfp & pf_or_bl;  // Playfield priority lifts pf and ball.

  // In score mode the playfield borrows the player colour of its half.
  assign score_pf = colors.score & ~colors.pfp & objs.pf;

  assign p0_hit = objs.p0 | objs.m0 | (score_pf & left_half);
  assign p1_hit = objs.p1 | objs.m1 | (score_pf & ~left_half);

  always_comb begin
    if (blank) begin
      win = src_none;
    end else if (pf_top) begin
      win = src_pf;
    end else if (p0_hit) begin
      win = src_p0;
    end else if (p1_hit) begin
      win = src_p1;
    end else if (pf_or_bl) begin
      win = src_pf;
    end else begin
      win = src_bk;
    end
  end

  // Colour select.
  always_comb begin
    case (win)
      src_p0:  sel_color = colors.colup0;
      src_p1:  sel_color = colors.colup1;
      src_pf:  sel_color = colors.colupf;
      src_bk:  sel_color = colors.colubk;
      default: sel_color = '0;  // Blank.
    endcase
  end

  // Output stage, one pixel clock of latency.
  always_ff @(posedge clkp) begin
    if (reset) begin
      lum     <= '0;
      hue     <= '0;
      blk_bar <= 1'b0;
    end else begin
      lum     <= sel_color.lum;
      hue     <= sel_color.hue;
      blk_bar <= ~blank;
    end
  end

endmodule

// File: src/tia_color_lum_top.sv
`timescale 1ns/10ps

module tia_color_lum_top (
  input  logic                               clkp,
  input  logic                               reset,
  input  logic                               psel,
  input  logic                               penable,
  input  logic                               pwrite,
  input  logic [tia_reg_pkg::apb_addr_w-1:0] paddr,
  input  logic [tia_reg_pkg::data_w-1:0]     pwdata,
  output logic [tia_reg_pkg::data_w-1:0]     prdata,
  output logic                               pready,
  output logic                               pslverr,
  input  logic                               p0,
  input  logic                               m0,
  input  logic                               p1,
  input  logic                               m1,
  input  logic                               pf,
  input  logic                               bl,
  input  logic                               blank,
  input  logic                               cntd,
  output logic [tia_video_pkg::lum_w-1:0]    lum,
  output logic [tia_video_pkg::hue_w-1:0]    hue,
  output logic                               blk_bar
);

  tia_color_if colors ();
  tia_obj_if   objs ();

  // Object coincidence inputs onto the object bus.
  assign objs.p0 = p0;
  assign objs.m0 = m0;
  assign objs.p1 = p1;
  assign objs.m1 = m1;
  assign objs.pf = pf;
  assign objs.bl = bl;

  tia_apb_regs i_tia_apb_regs (
    .clkp    (clkp),
    .reset   (reset),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .colors  (colors.regs)
  );

  tia_color_priority i_tia_color_priority (
    .clkp    (clkp),
    .reset   (reset),
    .blank   (blank),
    .cntd    (cntd),
    .colors  (colors.video),
    .objs    (objs.video),
    .lum     (lum),
    .hue     (hue),
    .blk_bar (blk_bar)
  );

endmodule

// File: dv/tia_color_lum_vectors.svh
localparam int num_vec = 34;

// Columns: ctrl {score, pfp}, objects {p0, m0, p1, m1, pf, bl}, blank,
// half to establish (1 left, 0 right), expected winning source.
localparam vec_t vectors [num_vec] = '{
  '{2'b00, 6'b000000, 1'b0, 1'b1, src_bk},  // Nothing present.
  '{2'b00, 6'b100000, 1'b0, 1'b0, src_p0},
  '{2'b00, 6'b010000, 1'b0, 1'b1, src_p0},
  '{2'b00, 6'b001000, 1'b0, 1'b0, src_p1},
  '{2'b00, 6'b000100, 1'b0, 1'b1, src_p1},
  '{2'b00, 6'b000010, 1'b0, 1'b0, src_pf},
  '{2'b00, 6'b000001, 1'b0, 1'b1, src_pf},
  '{2'b00, 6'b101000, 1'b0, 1'b0, src_p0},
  '{2'b00, 6'b010100, 1'b0, 1'b1, src_p0},
  '{2'b00, 6'b001010, 1'b0, 1'b0, src_p1},
  '{2'b00, 6'b000101, 1'b0, 1'b1, src_p1},
  '{2'b00, 6'b111111, 1'b0, 1'b0, src_p0},
  '{2'b00, 6'b100011, 1'b0, 1'b1, src_p0},
  '{2'b00, 6'b000011, 1'b0, 1'b0, src_pf},
  // Playfield priority.
  '{2'b01, 6'b100010, 1'b0, 1'b1, src_pf},
  '{2'b01, 6'b001001, 1'b0, 1'b0, src_pf},
  '{2'b01, 6'b111111, 1'b0, 1'b1, src_pf},
  '{2'b01, 6'b100000, 1'b0, 1'b0, src_p0},
  '{2'b01, 6'b001100, 1'b0, 1'b1, src_p1},
  '{2'b01, 6'b000000, 1'b0, 1'b0, src_bk},
  '{2'b01, 6'b010100, 1'b0, 1'b1, src_p0},
  // Score mode, playfield follows the player colour of its half.
  '{2'b10, 6'b000010, 1'b0, 1'b1, src_p0},
  '{2'b10, 6'b000010, 1'b0, 1'b0, src_p1},
  '{2'b10, 6'b000011, 1'b0, 1'b1, src_p0},
  '{2'b10, 6'b000001, 1'b0, 1'b1, src_pf},  // Ball keeps its own colour.
  '{2'b10, 6'b001010, 1'b0, 1'b1, src_p0},
  '{2'b10, 6'b100010, 1'b0, 1'b0, src_p0},
  '{2'b10, 6'b000000, 1'b0, 1'b1, src_bk},
  // Score with playfield priority.
  '{2'b11, 6'b000010, 1'b0, 1'b1, src_pf},
  '{2'b11, 6'b001010, 1'b0, 1'b0, src_pf},
  // Blanked pixels.
  '{2'b00, 6'b111111, 1'b1, 1'b0, src_none},
  '{2'b00, 6'b000000, 1'b1, 1'b1, src_none},
  '{2'b01, 6'b000010, 1'b1, 1'b0, src_none},
  '{2'b10, 6'b000010, 1'b1, 1'b1, src_none}
};

// File: dv/tia_color_lum_tb.sv
`timescale 1ns/10ps

module tia_color_lum_tb;

  import tia_reg_pkg::*;
  import tia_video_pkg::*;

  typedef struct packed {
    logic [1:0] ctrl;     // {score, pfp}.
    logic [5:0] objs;     // {p0, m0, p1, m1, pf, bl}.
    logic       blank;
    logic       left;     // Half established before the pixel.
    obj_src_t   exp_src;
  } vec_t;

  `include "tia_color_lum_vectors.svh"

  localparam int cycle_limit = num_vec * 8 + 200;

  logic                  clkp;
  logic                  reset;
  logic                  psel;
  logic                  penable;
  logic                  pwrite;
  logic [apb_addr_w-1:0] paddr;
  logic [data_w-1:0]     pwdata;
  logic [data_w-1:0]     prdata;
  logic                  pready;
  logic                  pslverr;
  logic                  p0;
  logic                  m0;
  logic                  p1;
  logic                  m1;
  logic                  pf;
  logic                  bl;
  logic                  blank;
  logic                  cntd;
  logic [lum_w-1:0]      lum;
  logic [hue_w-1:0]      hue;
  logic                  blk_bar;

  logic [data_w-1:0] color_wr [4];  // Last byte written to each colour register.
  logic [data_w-1:0] ctrl_wr;
  logic [data_w-1:0] new_color;
  integer            seed;
  int                cycles = 0;

  tia_color_lum_top i_tia_color_lum_top (
    .clkp    (clkp),
    .reset   (reset),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .p0      (p0),
    .m0      (m0),
    .p1      (p1),
    .m1      (m1),
    .pf      (pf),
    .bl      (bl),
    .blank   (blank),
    .cntd    (cntd),
    .lum     (lum),
    .hue     (hue),
    .blk_bar (blk_bar)
  );

  always #4 clkp = ~clkp;

  always @(posedge clkp) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("Timeout: the run went past %0d clock cycles.", cycle_limit);
      $display("TESTBENCH FAILED");
      $fatal(1, "Run stopped by the cycle limit.");
    end
  end

  task automatic report_mismatch(input string name, input logic [7:0] got,
                                 input logic [7:0] exp);
    $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
    $display("TESTBENCH FAILED");
    $fatal(1, "Run stopped at the first error.");
  endtask

  task automatic check_equal(input string name, input logic [7:0] got,
                             input logic [7:0] exp);
    assert (got === exp) else report_mismatch(name, got, exp);
  endtask

  task automatic apb_write(input logic [apb_addr_w-1:0] addr,
                           input logic [data_w-1:0] data, input logic exp_err);
    @(posedge clkp);
    psel    <= 1'b1;  // Setup phase.
    penable <= 1'b0;
    pwrite  <= 1'b1;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge clkp);
    penable <= 1'b1;
    @(negedge clkp);
    check_equal("pready", 8'(pready), 8'h01);
    check_equal("pslverr", 8'(pslverr), 8'(exp_err));
    @(posedge clkp);  // Write lands on this edge.
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  task automatic apb_read(input logic [apb_addr_w-1:0] addr,
                          input logic [data_w-1:0] exp_data, input logic exp_err);
    @(posedge clkp);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= addr;
    @(posedge clkp);
    penable <= 1'b1;
    @(negedge clkp);
    check_equal("pready", 8'(pready), 8'h01);
    check_equal("pslverr", 8'(pslverr), 8'(exp_err));
    check_equal("prdata", prdata, exp_data);
    @(posedge clkp);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic drive_pixel(input logic [5:0] objs_v, input logic blank_v,
                             input logic cntd_v);
    @(posedge clkp);
    {p0, m0, p1, m1, pf, bl} <= objs_v;
    blank <= blank_v;
    cntd  <= cntd_v;
  endtask

  // Stored colour keeps bits 7:1, hue in 7:4 and luminance in 3:1.
  function automatic logic [data_w-1:0] expected_color(input obj_src_t src);
    case (src)
      src_p0:  return color_wr[0] & 8'hfe;
      src_p1:  return color_wr[1] & 8'hfe;
      src_pf:  return color_wr[2] & 8'hfe;
      src_bk:  return color_wr[3] & 8'hfe;
      default: return 8'h00;
    endcase
  endfunction

  task automatic check_pixel(input obj_src_t src, input logic exp_blk_bar);
    logic [data_w-1:0] c;
    c = expected_color(src);
    check_equal("lum", 8'(lum), 8'(c[3:1]));
    check_equal("hue", 8'(hue), 8'(c[7:4]));
    check_equal("blk_bar", 8'(blk_bar), 8'(exp_blk_bar));
  endtask

  task automatic run_row(input vec_t v);
    logic [data_w-1:0] ctrl_data;
    ctrl_data = '0;
    ctrl_data[ctrlpf_score_bit] = v.ctrl[1];
    ctrl_data[ctrlpf_pfp_bit]   = v.ctrl[0];
    apb_write(addr_ctrlpf, ctrl_data, 1'b0);
    drive_pixel(6'b000000, v.left, ~v.left);  // Blank sets left, cntd clears it.
    drive_pixel(v.objs, v.blank, 1'b0);
    drive_pixel(6'b000000, 1'b0, 1'b0);
    @(negedge clkp);
    check_pixel(v.exp_src, ~v.blank);
    @(posedge clkp);
    @(negedge clkp);
    check_equal("blk_bar", 8'(blk_bar), 8'h01);  // Blank is low again.
  endtask

  initial begin
    seed    = 41;
    clkp    = 1'b0;
    reset   = 1'b1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    {p0, m0, p1, m1, pf, bl} = 6'b000000;
    blank   = 1'b0;
    cntd    = 1'b0;

    repeat (10) @(posedge clkp);
    reset <= 1'b0;
    @(negedge clkp);
    check_pixel(src_none, 1'b0);
    check_equal("pready", 8'(pready), 8'h00);
    check_equal("pslverr", 8'(pslverr), 8'h00);
    for (int a = 0; a < 5; a++) apb_read(3'(a), 8'h00, 1'b0);

    // Register write and read back.
    for (int i = 0; i < 4; i++) begin
      color_wr[i] = 8'($random(seed));
      apb_write(3'(i), color_wr[i], 1'b0);
    end
    ctrl_wr = 8'($random(seed));
    apb_write(addr_ctrlpf, ctrl_wr, 1'b0);
    for (int i = 0; i < 4; i++) apb_read(3'(i), color_wr[i] & 8'hfe, 1'b0);
    apb_read(addr_ctrlpf, ctrl_wr & 8'h06, 1'b0);

    // Unmapped offsets.
    for (int a = 5; a < 8; a++) begin
      apb_write(3'(a), 8'hff, 1'b1);
      apb_read(3'(a), 8'h00, 1'b1);
    end
    for (int i = 0; i < 4; i++) apb_read(3'(i), color_wr[i] & 8'hfe, 1'b0);
    apb_read(addr_ctrlpf, ctrl_wr & 8'h06, 1'b0);

    for (int r = 0; r < num_vec; r++) run_row(vectors[r]);

    // Player 0 colour rewritten while player 0 is shown.
    apb_write(addr_ctrlpf, 8'h00, 1'b0);
    drive_pixel(6'b100000, 1'b0, 1'b0);
    @(posedge clkp);
    @(negedge clkp);
    check_pixel(src_p0, 1'b1);
    new_color = color_wr[0] ^ 8'haa;
    apb_write(addr_colup0, new_color, 1'b0);
    @(negedge clkp);
    check_pixel(src_p0, 1'b1);  // Pixel sampled on the write edge.
    color_wr[0] = new_color;
    @(posedge clkp);
    @(negedge clkp);
    check_pixel(src_p0, 1'b1);
    drive_pixel(6'b000000, 1'b0, 1'b0);

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

// File: tia_color_lum_top.f
+incdir+dv
src/tia_reg_pkg.sv
src/tia_video_pkg.sv
src/tia_color_if.sv
src/tia_obj_if.sv
src/tia_apb_regs.sv
src/tia_color_priority.sv
src/tia_color_lum_top.sv
dv/tia_color_lum_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds and runs the colour and luminance testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
  --top-module tia_color_lum_tb \
  -f tia_color_lum_top.f \
  -o sim_tia_color_lum

sim_out=$(./obj_dir/sim_tia_color_lum 2>&1 || true)
echo "$sim_out"

if grep -q "TESTBENCH PASSED" <<< "$sim_out"; then
  echo "Simulation run passed."
  exit 0
else
  echo "Simulation run did not pass."
  exit 1
fi
